// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int xlen_p = 32;

    typedef logic [4:0] reg_idx_t;

    // Only the major opcodes this core executes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } funct3_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        funct3_e    funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        funct3_e     funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i_type_t;

    // Same 32-bit word seen as R-type or I-type
    typedef union packed {
        r_type_t r_fields;
        i_type_t i_fields;
    } instr_u;

    // ADDI x0, x0, 0
    localparam instr_u nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== design/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Decoded instruction crossing the ID/EX boundary
    typedef struct packed {
        logic               valid;
        logic               reg_write;
        logic               illegal;
        alu_op_e            alu_op;
        logic               b_is_imm;
        reg_idx_t           rd;
        reg_idx_t           rs1;
        reg_idx_t           rs2;
        logic [xlen_p-1:0]  rs1_data;
        logic [xlen_p-1:0]  rs2_data;
        logic [xlen_p-1:0]  imm;
    } id_ex_t;

    // Retired result, also the register file write request
    typedef struct packed {
        reg_idx_t           rd;
        logic [xlen_p-1:0]  result;
        logic               reg_write;
        logic               illegal;
    } wb_t;

endpackage

`default_nettype wire

// ==== design/rv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int XLEN = xlen_p
) (
    input  instr_u          instr,
    input  logic            instr_valid,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output reg_idx_t        rs1_idx,
    output reg_idx_t        rs2_idx,
    output id_ex_t          id
);

    instr_u          word;
    alu_op_e         alu_op;
    logic            b_is_imm;
    logic            illegal;
    logic [XLEN-1:0] imm;

    // Shared funct3 mapping for OP and OP-IMM; SUB exists only for OP
    function automatic alu_op_e alu_from_funct(funct3_e f3, logic alt, logic sub_ok);
        case (f3)
            ADD_SUB: return (alt && sub_ok) ? ALU_SUB : ALU_ADD;
            SLL:     return ALU_SLL;
            SLT:     return ALU_SLT;
            SLTU:    return ALU_SLTU;
            XOR:     return ALU_XOR;
            SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            OR:      return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Bubbles decode as a NOP so no stray indices reach the pipeline
    assign word = instr_valid ? instr : nop_instr;

    assign rs1_idx = word.i_fields.rs1;
    assign rs2_idx = word.r_fields.rs2;

    always_comb begin
        alu_op   = ALU_ADD;
        b_is_imm = 1'b0;
        illegal  = 1'b0;
        imm      = XLEN'($signed(word.i_fields.imm12));
        case (word.r_fields.opcode)
            OP: begin
                alu_op = alu_from_funct(word.r_fields.funct3, word.r_fields.funct7[5], 1'b1);
            end
            OP_IMM: begin
                b_is_imm = 1'b1;
                alu_op   = alu_from_funct(word.i_fields.funct3, word.r_fields.funct7[5], 1'b0);
            end
            LUI: begin
                b_is_imm = 1'b1;
                alu_op   = ALU_PASS_B;
                // Upper 20 bits span funct7..funct3 of the R-type view
                imm = XLEN'($signed({word.r_fields.funct7, word.r_fields.rs2,
                                     word.r_fields.rs1, word.r_fields.funct3, 12'b0}));
            end
            default: illegal = 1'b1;
        endcase
    end

    assign id = '{
        valid:     instr_valid,
        reg_write: !illegal && (word.i_fields.rd != '0),
        illegal:   illegal,
        alu_op:    alu_op,
        b_is_imm:  b_is_imm,
        rd:        word.i_fields.rd,
        rs1:       rs1_idx,
        rs2:       rs2_idx,
        rs1_data:  rs1_data,
        rs2_data:  rs2_data,
        imm:       imm
    };

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_regfile
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int XLEN = xlen_p
) (
    input  logic            clk,
    input  logic            reset,
    input  reg_idx_t        rs1_idx,
    input  reg_idx_t        rs2_idx,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data,
    input  wb_t             wr,
    input  logic            wr_en
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];
    logic            wr_live;

    assign wr_live = wr_en && (wr.rd != '0);

    // Write-through so a same-cycle reader sees the retiring value
    function automatic logic [XLEN-1:0] read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wr_live && (wr.rd == idx)) begin
            return wr.result;
        end
        return regs[idx];
    endfunction

    // Architectural state starts at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr.rd] <= wr.result;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

endmodule

`default_nettype wire

// ==== design/rv_reg_id_ex.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_reg_id_ex
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int XLEN      = xlen_p,
    parameter int PIPELINED = 1
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,
    input  id_ex_t id,
    output id_ex_t ex
);

    if (PIPELINED != 0) begin : g_registered
        logic            valid_q;
        logic            reg_write_q;
        logic            illegal_q;
        alu_op_e         alu_op_q;
        logic            b_is_imm_q;
        reg_idx_t        rd_q;
        reg_idx_t        rs1_q;
        reg_idx_t        rs2_q;
        logic [XLEN-1:0] rs1_data_q;
        logic [XLEN-1:0] rs2_data_q;
        logic [XLEN-1:0] imm_q;

        // Control fields
        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q     <= 1'b0;
                reg_write_q <= 1'b0;
                illegal_q   <= 1'b0;
            end else if (!stall) begin
                valid_q     <= id.valid;
                reg_write_q <= id.reg_write;
                illegal_q   <= id.illegal;
            end
        end

        // Payload, only meaningful while valid_q is set
        always_ff @(posedge clk) begin
            if (!stall) begin
                alu_op_q   <= id.alu_op;
                b_is_imm_q <= id.b_is_imm;
                rd_q       <= id.rd;
                rs1_q      <= id.rs1;
                rs2_q      <= id.rs2;
                rs1_data_q <= id.rs1_data;
                rs2_data_q <= id.rs2_data;
                imm_q      <= id.imm;
            end
        end

        assign ex = '{
            valid:     valid_q,
            reg_write: reg_write_q,
            illegal:   illegal_q,
            alu_op:    alu_op_q,
            b_is_imm:  b_is_imm_q,
            rd:        rd_q,
            rs1:       rs1_q,
            rs2:       rs2_q,
            rs1_data:  rs1_data_q,
            rs2_data:  rs2_data_q,
            imm:       imm_q
        };
    end else begin : g_passthrough
        // Decode feeds execute directly
        assign ex = id;
    end

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_execute
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int XLEN = xlen_p
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,
    input  id_ex_t ex,
    output wb_t    wb,
    output logic   wb_valid
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic               fwd_ok;
    logic               fwd_a;
    logic               fwd_b;
    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    rs2_val;
    logic [XLEN-1:0]    op_b;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    alu_res;
    logic               reg_write_q;
    logic               illegal_q;
    reg_idx_t           rd_q;
    logic [XLEN-1:0]    result_q;

    // Held EX/WB entry is the only result not yet visible in the register file
    assign fwd_ok = wb_valid && reg_write_q && (rd_q != '0);
    assign fwd_a  = fwd_ok && (rd_q == ex.rs1);
    assign fwd_b  = fwd_ok && (rd_q == ex.rs2);

    assign op_a    = fwd_a ? result_q : ex.rs1_data;
    assign rs2_val = fwd_b ? result_q : ex.rs2_data;
    assign op_b    = ex.b_is_imm ? ex.imm : rs2_val;
    assign shamt   = op_b[SHAMT_W-1:0];

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = XLEN'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid    <= 1'b0;
            reg_write_q <= 1'b0;
            illegal_q   <= 1'b0;
        end else if (!stall) begin
            wb_valid    <= ex.valid;
            reg_write_q <= ex.valid && ex.reg_write;
            illegal_q   <= ex.valid && ex.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rd_q     <= ex.rd;
            result_q <= alu_res;
        end
    end

    assign wb = '{rd: rd_q, result: result_q, reg_write: reg_write_q, illegal: illegal_q};

endmodule

`default_nettype wire

// ==== design/rv_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_top
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int XLEN      = xlen_p,
    parameter int PIPELINED = 1
) (
    input  logic   clk,
    input  logic   reset,
    input  instr_u instr,
    input  logic   instr_valid,
    output logic   instr_ready,
    output wb_t    wb,
    output logic   wb_valid,
    input  logic   wb_ready
);

    logic            stall;
    logic            wr_en;
    reg_idx_t        rs1_idx;
    reg_idx_t        rs2_idx;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    id_ex_t          id_bundle;
    id_ex_t          ex_bundle;

    // Whole pipeline freezes while the retiring result is not taken
    assign stall       = wb_valid && !wb_ready;
    assign instr_ready = !stall;

    // Register file updates only on the retirement handshake
    assign wr_en = wb_valid && wb_ready && wb.reg_write && (wb.rd != '0);

    rv_decode #(
        .XLEN(XLEN)
    ) i_decode (
        .instr      (instr),
        .instr_valid(instr_valid),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .id         (id_bundle)
    );

    rv_regfile #(
        .XLEN(XLEN)
    ) i_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wr      (wb),
        .wr_en   (wr_en)
    );

    rv_reg_id_ex #(
        .XLEN     (XLEN),
        .PIPELINED(PIPELINED)
    ) i_reg_id_ex (
        .clk  (clk),
        .reset(reset),
        .stall(stall),
        .id   (id_bundle),
        .ex   (ex_bundle)
    );

    rv_execute #(
        .XLEN(XLEN)
    ) i_execute (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .ex      (ex_bundle),
        .wb      (wb),
        .wb_valid(wb_valid)
    );

endmodule

`default_nettype wire

// ==== testbench/rv_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    localparam int num_instr    = 30;
    localparam int accept_limit = 100;
    localparam int drain_limit  = 100;

    // One stimulus line: the instruction and what it should retire with
    typedef struct packed {
        instr_u            instr;
        reg_idx_t          rd;
        logic [xlen_p-1:0] result;
        logic              illegal;
    } stim_rec_t;

    logic        clk;
    logic        reset;
    instr_u      instr;
    logic        instr_valid;
    logic        instr_ready;
    wb_t         wb;
    logic        wb_valid;
    logic        wb_ready;

    logic [31:0] stim_words [0:4*num_instr-1];
    stim_rec_t   recs [num_instr];
    int          retired;
    int          value_errors;
    int          other_errors;
    logic        hung;

    rv_core_top #(
        .XLEN     (xlen_p),
        .PIPELINED(1)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .wb         (wb),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Random back-pressure on the writeback stream, ready about three cycles in four
    initial begin
        wb_ready = 1'b0;
        void'($urandom(32'h4872));
        forever begin
            @(posedge clk);
            wb_ready <= ($urandom % 4) != 0;
        end
    end

    // Neither x0 nor an illegal opcode writes a register
    function automatic wb_t expected_wb(stim_rec_t rec);
        wb_t want;
        want.rd        = rec.rd;
        want.result    = rec.result;
        want.illegal   = rec.illegal;
        want.reg_write = !rec.illegal && (rec.rd != '0);
        return want;
    endfunction

    task automatic check_wb(int idx, wb_t got, wb_t want);
        if (got.rd !== want.rd) begin
            $display("Mismatch at time %0t: retirement %0d rd is %0d, expected %0d",
                     $time, idx, got.rd, want.rd);
            value_errors++;
        end
        if (got.reg_write !== want.reg_write) begin
            $display("Mismatch at time %0t: retirement %0d reg_write is %b, expected %b",
                     $time, idx, got.reg_write, want.reg_write);
            value_errors++;
        end
        if (got.illegal !== want.illegal) begin
            $display("Mismatch at time %0t: retirement %0d illegal is %b, expected %b",
                     $time, idx, got.illegal, want.illegal);
            value_errors++;
        end
        // The result of an illegal instruction carries no meaning
        if (!want.illegal && (got.result !== want.result)) begin
            $display("Mismatch at time %0t: retirement %0d result is %h, expected %h",
                     $time, idx, got.result, want.result);
            value_errors++;
        end
    endtask

    task automatic check_count(int got, int want);
        if (got !== want) begin
            $display("Mismatch at time %0t: %0d instructions retired, expected %0d",
                     $time, got, want);
            value_errors++;
        end
    endtask

    task automatic await_accept(int idx, output logic timed_out);
        int   cycles;
        logic accepted;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted && cycles < accept_limit) begin
            @(posedge clk);
            accepted = instr_ready;
            cycles++;
        end
        timed_out = !accepted;
        if (!accepted) begin
            $display("Instruction %0d was not accepted within %0d cycles, the input stream hung",
                     idx, accept_limit);
            other_errors++;
        end
    endtask

    task automatic drain_pipeline(output logic timed_out);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (retired < num_instr && cycles < drain_limit);
        timed_out = (retired < num_instr);
        if (timed_out) begin
            $display("Only %0d of %0d instructions retired within %0d cycles, writeback hung",
                     retired, num_instr, drain_limit);
            other_errors++;
        end
    endtask

    // Retirements are matched against the stimulus in order
    always @(posedge clk) begin
        if (!reset && wb_valid && wb_ready) begin
            if (retired < num_instr) begin
                check_wb(retired, wb, expected_wb(recs[retired]));
            end else begin
                $display("Extra retirement at time %0t after all %0d instructions retired",
                         $time, num_instr);
                other_errors++;
            end
            retired++;
        end
    end

    initial begin
        logic timed_out;
        reset        = 1'b1;
        instr        = nop_instr;
        instr_valid  = 1'b0;
        retired      = 0;
        value_errors = 0;
        other_errors = 0;
        hung         = 1'b0;
        timed_out    = 1'b0;

        $readmemh("testbench/rv_core_stim.txt", stim_words);
        if ($isunknown(stim_words[4*num_instr-1])) begin
            $display("The stimulus file holds fewer than %0d instructions", num_instr);
            other_errors++;
        end
        for (int i = 0; i < num_instr; i++) begin
            recs[i].instr   = stim_words[4*i];
            recs[i].rd      = reg_idx_t'(stim_words[4*i+1]);
            recs[i].result  = stim_words[4*i+2];
            recs[i].illegal = stim_words[4*i+3][0];
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Next word goes out on the same edge that accepted the previous one
        for (int i = 0; i < num_instr && !hung; i++) begin
            instr       <= recs[i].instr;
            instr_valid <= 1'b1;
            await_accept(i, timed_out);
            hung = timed_out;
        end
        instr_valid <= 1'b0;
        instr       <= nop_instr;

        if (!hung) begin
            drain_pipeline(timed_out);
            hung = timed_out;
        end
        if (!hung) begin
            // Idle cycles expose a duplicated retirement
            repeat (4) @(negedge clk);
            check_count(retired, num_instr);
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/rv_core_stim.txt ====
// Columns: instruction word, expected rd, expected result, expected illegal flag
// Registers start at zero; an illegal line's result column is not compared
00500093 01 00000005 0  // addi x1, x0, 5
FFD00113 02 FFFFFFFD 0  // addi x2, x0, -3
002081B3 03 00000002 0  // add  x3, x1, x2
40208233 04 00000008 0  // sub  x4, x1, x2
003092B3 05 00000014 0  // sll  x5, x1, x3
40315333 06 FFFFFFFF 0  // sra  x6, x2, x3
003153B3 07 3FFFFFFF 0  // srl  x7, x2, x3
00112433 08 00000001 0  // slt  x8, x2, x1
001134B3 09 00000000 0  // sltu x9, x2, x1
0020C533 0A FFFFFFF8 0  // xor  x10, x1, x2
0040E5B3 0B 0000000D 0  // or   x11, x1, x4
00417633 0C 00000008 0  // and  x12, x2, x4
123456B7 0D 12345000 0  // lui  x13, 0x12345
67868693 0D 12345678 0  // addi x13, x13, 0x678
00100713 0E 00000001 0  // addi x14, x0, 1
00E70733 0E 00000002 0  // add  x14, x14, x14
00E70733 0E 00000004 0  // add  x14, x14, x14
00A70713 0E 0000000E 0  // addi x14, x14, 10
00471713 0E 000000E0 0  // slli x14, x14, 4
40115793 0F FFFFFFFE 0  // srai x15, x2, 1
FFF0B813 10 00000001 0  // sltiu x16, x1, -1
FFF74893 11 FFFFFF1F 0  // xori x17, x14, -1
00708013 00 0000000C 0  // addi x0, x1, 7
00106933 12 00000005 0  // or   x18, x0, x1
000000FF 01 00000000 1  // unknown opcode, rd field x1
00008993 13 00000005 0  // addi x19, x1, 0
FFFFFFFF 1F 00000000 1  // unknown opcode, rd field x31
003F8A13 14 00000003 0  // addi x20, x31, 3
FFE12A93 15 00000001 0  // slti x21, x2, -2
0FF6FB13 16 00000078 0  // andi x22, x13, 0xff

// ==== compile.f ====
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_reg_id_ex.sv
design/rv_execute.sv
design/rv_core_top.sv
testbench/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - design/rv_isa_pkg.sv
  - design/rv_pipe_pkg.sv
  - design/rv_decode.sv
  - design/rv_regfile.sv
  - design/rv_reg_id_ex.sv
  - design/rv_execute.sv
  - design/rv_core_top.sv
  - target: test
    files:
      - testbench/rv_core_tb.sv
